// File: hw/dispatch_unit.sv
// Sends the car to the top request and retires it on arrival.
// Also gates the door buttons and raises the global request clear.

`timescale 1ns/1ps

module dispatch_unit (
    input  logic                     clock,
    input  logic                     reset_n,
    input  logic                     power_switch,
    input  logic                     emergency_btn,
    input  logic                     car_stopped,
    input  logic                     door_open_btn,
    input  logic                     door_close_btn,
    input  elevator_pkg::floor_t     current_floor,
    stack_if.dispatch                stack,
    output elevator_pkg::floor_t     target_floor,
    output elevator_pkg::direction_t direction,
    output logic                     activate_elevator,
    output logic                     served,
    output elevator_pkg::floor_t     served_floor,
    output logic                     clear_all,
    output logic                     door_open_allowed,
    output logic                     door_close_allowed
);

    elevator_pkg::dispatch_state_t state;
    logic                          serve_here;
    logic                          arrived;

    function automatic elevator_pkg::direction_t dir_toward(
        input elevator_pkg::floor_t dest,
        input elevator_pkg::floor_t from
    );
        return (dest > from) ? elevator_pkg::DIR_UP : elevator_pkg::DIR_DOWN;
    endfunction

    // Power loss or emergency drops every pending request
    assign clear_all         = !power_switch || emergency_btn;
    assign stack.flush       = clear_all;
    assign activate_elevator = (state == elevator_pkg::DISPATCH_TRAVEL);

    ////////////////////////////////////////////////////////////
    // Service conditions
    ////////////////////////////////////////////////////////////

    // Top request already at the car, served without moving
    assign serve_here = (state == elevator_pkg::DISPATCH_IDLE) && car_stopped &&
                        stack.top_valid && (stack.top_floor == current_floor);

    assign arrived    = (state == elevator_pkg::DISPATCH_TRAVEL) && car_stopped &&
                        stack.top_valid && (current_floor == target_floor) &&
                        (stack.top_floor == target_floor);

    assign stack.pop_ready = !clear_all && (serve_here || arrived);

    ////////////////////////////////////////////////////////////
    // Dispatch FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state        <= elevator_pkg::DISPATCH_IDLE;
            target_floor <= '0;
            direction    <= elevator_pkg::DIR_DOWN;
            served       <= 1'b0;
        end else begin
            served <= stack.pop_ready;
            if (clear_all) begin
                state <= elevator_pkg::DISPATCH_IDLE;
            end else begin
                case (state)
                    elevator_pkg::DISPATCH_IDLE: begin
                        if (car_stopped && stack.top_valid && !serve_here) begin
                            state        <= elevator_pkg::DISPATCH_TRAVEL;
                            target_floor <= stack.top_floor;
                            direction    <= dir_toward(stack.top_floor, current_floor);
                        end
                    end
                    elevator_pkg::DISPATCH_TRAVEL: begin
                        if (arrived) begin
                            state <= elevator_pkg::DISPATCH_IDLE;
                        end else if (stack.top_valid && stack.top_floor != target_floor) begin
                            // A newer request took the top, head there instead
                            target_floor <= stack.top_floor;
                            direction    <= dir_toward(stack.top_floor, current_floor);
                        end
                    end
                    default: state <= elevator_pkg::DISPATCH_IDLE;
                endcase
            end
        end
    end

    // Floor reported to the latch along with the served strobe
    always_ff @(posedge clock) begin
        if (stack.pop_ready) begin
            served_floor <= stack.top_floor;
        end
    end

    // Doors respond only to a stopped, powered car
    assign door_open_allowed  = car_stopped && power_switch && door_open_btn;
    assign door_close_allowed = car_stopped && power_switch && door_close_btn;

endmodule

// File: hw/elevator_cfg.svh
// Sizing of the elevator request controller.
// Include this file wherever floor counts or the stack depth are needed.

`ifndef ELEVATOR_CFG_SVH
`define ELEVATOR_CFG_SVH

// Floors served by the car, one button and one light per floor
`define NUM_FLOORS 11

// Bits in a floor code
`define FLOOR_W 4

// Pending requests the floor stack can hold
`define STACK_DEPTH 11

`endif

// File: hw/elevator_pkg.sv
// Types describing the car itself.
// Floor codes, travel direction and the dispatcher state.

`include "elevator_cfg.svh"

package elevator_pkg;

    ////////////////////////////////////////////////////////////
    // Car position and motion
    ////////////////////////////////////////////////////////////

    // Floor 0 is the lowest floor
    typedef logic [`FLOOR_W-1:0] floor_t;

    typedef enum logic {
        DIR_DOWN = 1'b0,
        DIR_UP   = 1'b1
    } direction_t;

    ////////////////////////////////////////////////////////////
    // Dispatcher
    ////////////////////////////////////////////////////////////

    typedef enum logic {
        DISPATCH_IDLE   = 1'b0,
        DISPATCH_TRAVEL = 1'b1
    } dispatch_state_t;

endpackage

// File: hw/floor_request_controller.sv
// Floor request controller for an 11-floor elevator car.
// Connects button capture, the floor stack and the dispatcher.

`timescale 1ns/1ps
`include "elevator_cfg.svh"

module floor_request_controller (
    input  logic                     clock,
    input  logic                     reset_n,

    // Buttons
    input  logic [`NUM_FLOORS-1:0]   floor_call_buttons,
    input  logic [`NUM_FLOORS-1:0]   panel_buttons,
    input  logic                     door_open_btn,
    input  logic                     door_close_btn,
    input  logic                     emergency_btn,
    input  logic                     power_switch,

    // Car status
    input  logic                     car_stopped,
    input  elevator_pkg::floor_t     current_floor,

    // Car commands
    output elevator_pkg::floor_t     target_floor,
    output elevator_pkg::direction_t direction,
    output logic                     activate_elevator,
    output logic                     door_open_allowed,
    output logic                     door_close_allowed,

    // Lights
    output logic [`NUM_FLOORS-1:0]   call_button_lights,
    output logic [`NUM_FLOORS-1:0]   panel_button_lights
);

    logic                 served;
    elevator_pkg::floor_t served_floor;
    logic                 clear_all;

    stack_if stack_bus ();

    ////////////////////////////////////////////////////////////
    // Units
    ////////////////////////////////////////////////////////////

    request_latch request_latch_inst (
        .clock               (clock),
        .reset_n             (reset_n),
        .floor_call_buttons  (floor_call_buttons),
        .panel_buttons       (panel_buttons),
        .current_floor       (current_floor),
        .clear_all           (clear_all),
        .served              (served),
        .served_floor        (served_floor),
        .stack               (stack_bus.latch),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights)
    );

    floor_stack floor_stack_inst (
        .clock   (clock),
        .reset_n (reset_n),
        .stack   (stack_bus.stack)
    );

    dispatch_unit dispatch_unit_inst (
        .clock              (clock),
        .reset_n            (reset_n),
        .power_switch       (power_switch),
        .emergency_btn      (emergency_btn),
        .car_stopped        (car_stopped),
        .door_open_btn      (door_open_btn),
        .door_close_btn     (door_close_btn),
        .current_floor      (current_floor),
        .stack              (stack_bus.dispatch),
        .target_floor       (target_floor),
        .direction          (direction),
        .activate_elevator  (activate_elevator),
        .served             (served),
        .served_floor       (served_floor),
        .clear_all          (clear_all),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

endmodule

// File: hw/floor_stack.sv
// Last-in, first-out store of accepted floor requests.
// The top entry is always visible, a flush drops everything.

`timescale 1ns/1ps
`include "elevator_cfg.svh"

module floor_stack (
    input  logic   clock,
    input  logic   reset_n,
    stack_if.stack stack
);

    elevator_pkg::floor_t      entries [`STACK_DEPTH];
    request_pkg::stack_count_t count;
    request_pkg::stack_count_t top_idx;
    logic                      do_push;
    logic                      do_pop;

    ////////////////////////////////////////////////////////////
    // Handshake status
    ////////////////////////////////////////////////////////////

    assign stack.push_ready = (count != request_pkg::stack_count_t'(`STACK_DEPTH));
    assign stack.top_valid  = (count != '0);

    assign top_idx          = count - 1'b1;
    assign stack.top_floor  = stack.top_valid ? entries[top_idx] : '0;

    assign do_push = stack.push_valid && stack.push_ready;
    assign do_pop  = stack.top_valid && stack.pop_ready;

    ////////////////////////////////////////////////////////////
    // Pointer and storage
    ////////////////////////////////////////////////////////////

    // Push and pop together leave the count unchanged
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            count <= '0;
        end else if (stack.flush) begin
            count <= '0;
        end else if (do_push && !do_pop) begin
            count <= count + 1'b1;
        end else if (do_pop && !do_push) begin
            count <= count - 1'b1;
        end
    end

    // On a combined push and pop the new floor replaces the served top
    always_ff @(posedge clock) begin
        if (do_push && !stack.flush) begin
            if (do_pop) begin
                entries[top_idx] <= stack.push_floor;
            end else begin
                entries[count] <= stack.push_floor;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    a_count_in_range: assert property (
        @(posedge clock) disable iff (!reset_n)
        count <= request_pkg::stack_count_t'(`STACK_DEPTH)
    );

    // The dispatcher only asks for a pop while a request is pending
    a_no_pop_when_empty: assert property (
        @(posedge clock) disable iff (!reset_n)
        stack.pop_ready |-> stack.top_valid
    );

endmodule

// File: hw/request_latch.sv
// Captures panel and hall call buttons and owns their lights.
// Offers at most one new floor per cycle to the floor stack.

`timescale 1ns/1ps
`include "elevator_cfg.svh"

module request_latch (
    input  logic                   clock,
    input  logic                   reset_n,
    input  logic [`NUM_FLOORS-1:0] floor_call_buttons,
    input  logic [`NUM_FLOORS-1:0] panel_buttons,
    input  elevator_pkg::floor_t   current_floor,
    input  logic                   clear_all,
    input  logic                   served,
    input  elevator_pkg::floor_t   served_floor,
    stack_if.latch                 stack,
    output logic [`NUM_FLOORS-1:0] call_button_lights,
    output logic [`NUM_FLOORS-1:0] panel_button_lights
);

    logic                         pick_found;
    elevator_pkg::floor_t         pick_floor;
    request_pkg::request_source_t pick_src;
    logic                         accept;
    logic [`NUM_FLOORS-1:0]       floor_mask;
    logic [`NUM_FLOORS-1:0]       served_mask;
    logic [`NUM_FLOORS-1:0]       panel_set;
    logic [`NUM_FLOORS-1:0]       call_set;

    ////////////////////////////////////////////////////////////
    // Request arbitration
    ////////////////////////////////////////////////////////////

    // Panel first, then hall calls, lowest floor wins within each group
    always_comb begin
        pick_found = 1'b0;
        pick_floor = '0;
        pick_src   = request_pkg::SRC_PANEL;
        for (int f = 0; f < `NUM_FLOORS; f++) begin
            if (!pick_found && panel_buttons[f] && !panel_button_lights[f] &&
                elevator_pkg::floor_t'(f) != current_floor) begin
                pick_found = 1'b1;
                pick_floor = elevator_pkg::floor_t'(f);
                pick_src   = request_pkg::SRC_PANEL;
            end
        end
        for (int f = 0; f < `NUM_FLOORS; f++) begin
            if (!pick_found && floor_call_buttons[f] && !call_button_lights[f] &&
                elevator_pkg::floor_t'(f) != current_floor) begin
                pick_found = 1'b1;
                pick_floor = elevator_pkg::floor_t'(f);
                pick_src   = request_pkg::SRC_CALL;
            end
        end
    end

    assign stack.push_valid = pick_found && !clear_all;
    assign stack.push_floor = pick_floor;
    assign accept           = stack.push_valid && stack.push_ready;

    ////////////////////////////////////////////////////////////
    // Button lights
    ////////////////////////////////////////////////////////////

    always_comb begin
        floor_mask  = '0;
        served_mask = '0;
        for (int f = 0; f < `NUM_FLOORS; f++) begin
            floor_mask[f]  = (pick_floor == elevator_pkg::floor_t'(f));
            served_mask[f] = served && (served_floor == elevator_pkg::floor_t'(f));
        end
    end

    assign panel_set = (accept && pick_src == request_pkg::SRC_PANEL) ? floor_mask : '0;
    assign call_set  = (accept && pick_src == request_pkg::SRC_CALL) ? floor_mask : '0;

    // A new acceptance wins over a clear of the same floor
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            panel_button_lights <= '0;
            call_button_lights  <= '0;
        end else if (clear_all) begin
            panel_button_lights <= '0;
            call_button_lights  <= '0;
        end else begin
            panel_button_lights <= (panel_button_lights & ~served_mask) | panel_set;
            call_button_lights  <= (call_button_lights & ~served_mask) | call_set;
        end
    end

    // The car's own floor never enters the stack
    a_no_push_current_floor: assert property (
        @(posedge clock) disable iff (!reset_n)
        stack.push_valid |-> (stack.push_floor != current_floor)
    );

endmodule

// File: hw/request_pkg.sv
// Types describing pending requests.
// Where a request came from and how full the floor stack is.

`include "elevator_cfg.svh"

package request_pkg;

    // Selects which light an accepted push turns on
    typedef enum logic {
        SRC_PANEL = 1'b0,
        SRC_CALL  = 1'b1
    } request_source_t;

    // Occupancy of the floor stack, 0 up to the full depth
    typedef logic [$clog2(`STACK_DEPTH + 1)-1:0] stack_count_t;

endpackage

// File: hw/stack_if.sv
// Push, pop and flush channel around the floor stack.
// The request latch pushes, the dispatcher pops and flushes.

`timescale 1ns/1ps

interface stack_if;
    // Push side, a push happens when valid and ready are both high
    logic                 push_valid;
    elevator_pkg::floor_t push_floor;
    logic                 push_ready;

    // Pop side, top_valid means the stack is not empty
    logic                 top_valid;
    elevator_pkg::floor_t top_floor;
    logic                 pop_ready;

    // Empties the stack on the next edge
    logic                 flush;

    modport latch (output push_valid, output push_floor, input push_ready);

    modport stack (
        input  push_valid, input  push_floor, output push_ready,
        output top_valid,  output top_floor,  input  pop_ready,
        input  flush
    );

    modport dispatch (input top_valid, input top_floor, output pop_ready, output flush);
endinterface

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the floor request controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f \
    --top-module tb_floor_request_controller -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
    echo "Run result: pass"
else
    echo "Run result: fail"
    exit 1
fi

// File: sim.f
+incdir+hw
hw/elevator_pkg.sv
hw/request_pkg.sv
hw/stack_if.sv
hw/request_latch.sv
hw/floor_stack.sv
hw/dispatch_unit.sv
hw/floor_request_controller.sv
tests/request_checker.sv
tests/tb_floor_request_controller.sv

// File: tests/floor_requests_tests.txt
// One step per word: top digit is the step code, low three digits the argument
// 1 panel press, 2 call press, 3 move car (expected target), 4 power, 5 emergency,
// 6 expect panel lights, 7 expect call lights, 8 wait cycles, 9 door buttons,
// A expect activate, B expect door permissions {close,open}, 0 end
1003 1000 8002 6008 7000
2007 1005 8002 6028 7080
3005 8002 6008 7080
3007 8002 6008 7000
3003 8002 6000 7000 A000
1000 1001 1002 1004 1005 1006 1007 1008 1009 100A 2000
2001 8002 67F7 7001
3000 8002 67F6 7000
2001 8002 7002
3001 8002 67F4 7000
5001 8002 6000 7000 A000
5000 8004 A000
1006 8002 6040
4000 8002 6000 A000
9003 8001 B000
4001 8001 B003
9001 8001 B001
9000 8001 B000
9003 1002 3002 8001 B003
9000 8001 B000
0000

// File: tests/request_checker.sv
// Watches the floor request controller and compares it with a reference model.
// The model keeps a LIFO of floors, the expected lights and the dispatch state.
// The testbench calls check_value, note_failure and report by hierarchical name.

`timescale 1ns/1ps
`include "elevator_cfg.svh"

module request_checker (
    input logic                     clock,
    input logic                     reset_n,
    input logic [`NUM_FLOORS-1:0]   floor_call_buttons,
    input logic [`NUM_FLOORS-1:0]   panel_buttons,
    input logic                     door_open_btn,
    input logic                     door_close_btn,
    input logic                     emergency_btn,
    input logic                     power_switch,
    input logic                     car_stopped,
    input elevator_pkg::floor_t     current_floor,
    input elevator_pkg::floor_t     target_floor,
    input elevator_pkg::direction_t direction,
    input logic                     activate_elevator,
    input logic                     door_open_allowed,
    input logic                     door_close_allowed,
    input logic [`NUM_FLOORS-1:0]   call_button_lights,
    input logic [`NUM_FLOORS-1:0]   panel_button_lights
);

    int value_errors = 0;
    int other_errors = 0;

    // Model state
    logic [`NUM_FLOORS-1:0]    m_panel;
    logic [`NUM_FLOORS-1:0]    m_call;
    elevator_pkg::floor_t      m_stack [`STACK_DEPTH];
    request_pkg::stack_count_t m_count;
    logic                      m_travel;
    elevator_pkg::floor_t      m_target;
    logic                      m_up;
    logic                      m_served;
    elevator_pkg::floor_t      m_served_floor;

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic note_failure(input string msg);
        other_errors++;
        $display("Failure at %0t: %s", $time, msg);
    endtask

    task automatic report();
        $display("Check summary: %0d value errors, %0d other errors",
                 value_errors, other_errors);
    endtask

    task automatic compare_outputs();
        check_value("panel_button_lights", 16'(panel_button_lights), 16'(m_panel));
        check_value("call_button_lights", 16'(call_button_lights), 16'(m_call));
        check_value("activate_elevator", 16'(activate_elevator), 16'(m_travel));
        check_value("target_floor", 16'(target_floor), 16'(m_target));
        check_value("direction", 16'(direction), 16'(m_up));
        check_value("door_open_allowed", 16'(door_open_allowed),
                    16'(car_stopped && power_switch && door_open_btn));
        check_value("door_close_allowed", 16'(door_close_allowed),
                    16'(car_stopped && power_switch && door_close_btn));
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model, one step per rising edge
    ////////////////////////////////////////////////////////////

    always @(posedge clock) begin : model_step
        logic                   clear;
        logic                   found;
        logic                   from_panel;
        logic                   accept;
        logic                   here;
        logic                   arrive;
        logic                   pop;
        elevator_pkg::floor_t   pick;
        elevator_pkg::floor_t   top;
        logic [`NUM_FLOORS-1:0] smask;
        logic [`NUM_FLOORS-1:0] set_panel;
        logic [`NUM_FLOORS-1:0] set_call;

        if (!reset_n) begin
            m_panel        = '0;
            m_call         = '0;
            m_count        = '0;
            m_travel       = 1'b0;
            m_target       = '0;
            m_up           = 1'b0;
            m_served       = 1'b0;
            m_served_floor = '0;
        end else begin
            compare_outputs();
            clear = !power_switch || emergency_btn;
            top   = (m_count != '0) ? m_stack[m_count - 1'b1] : '0;

            // New request, panel before hall call, lowest floor first
            found      = 1'b0;
            from_panel = 1'b1;
            pick       = '0;
            for (int f = 0; f < `NUM_FLOORS; f++) begin
                if (!found && panel_buttons[f] && !m_panel[f] &&
                    elevator_pkg::floor_t'(f) != current_floor) begin
                    found = 1'b1;
                    pick  = elevator_pkg::floor_t'(f);
                end
            end
            for (int f = 0; f < `NUM_FLOORS; f++) begin
                if (!found && floor_call_buttons[f] && !m_call[f] &&
                    elevator_pkg::floor_t'(f) != current_floor) begin
                    found      = 1'b1;
                    from_panel = 1'b0;
                    pick       = elevator_pkg::floor_t'(f);
                end
            end
            accept = found && !clear &&
                     (m_count != request_pkg::stack_count_t'(`STACK_DEPTH));

            here   = !m_travel && car_stopped && (m_count != '0) && (top == current_floor);
            arrive = m_travel && car_stopped && (m_count != '0) &&
                     (current_floor == m_target) && (top == m_target);
            pop    = !clear && (here || arrive);

            smask     = m_served ? (`NUM_FLOORS'(1) << m_served_floor) : '0;
            set_panel = (accept && from_panel) ? (`NUM_FLOORS'(1) << pick) : '0;
            set_call  = (accept && !from_panel) ? (`NUM_FLOORS'(1) << pick) : '0;

            m_served = pop;
            if (pop) begin
                m_served_floor = top;
            end

            if (clear) begin
                m_panel  = '0;
                m_call   = '0;
                m_count  = '0;
                m_travel = 1'b0;
            end else begin
                m_panel = (m_panel & ~smask) | set_panel;
                m_call  = (m_call & ~smask) | set_call;
                // Dispatch decisions use the stack as it stood before this edge
                if (!m_travel) begin
                    if (car_stopped && (m_count != '0) && !here) begin
                        m_travel = 1'b1;
                        m_target = top;
                        m_up     = (top > current_floor);
                    end
                end else if (arrive) begin
                    m_travel = 1'b0;
                end else if ((m_count != '0) && top != m_target) begin
                    m_target = top;
                    m_up     = (top > current_floor);
                end
                if (pop) begin
                    m_count = m_count - 1'b1;
                end
                if (accept) begin
                    m_stack[m_count] = pick;
                    m_count          = m_count + 1'b1;
                end
            end
        end
    end

endmodule

// File: tests/tb_floor_request_controller.sv
// Testbench for the floor request controller.
// Runs the steps of tests/floor_requests_tests.txt against the DUT and a simple
// car model; request_checker does all comparing.

`timescale 1ns/1ps
`include "elevator_cfg.svh"

module tb_floor_request_controller;

    localparam int max_steps = 128;

    logic                     clock;
    logic                     reset_n;
    logic [`NUM_FLOORS-1:0]   floor_call_buttons;
    logic [`NUM_FLOORS-1:0]   panel_buttons;
    logic                     door_open_btn;
    logic                     door_close_btn;
    logic                     emergency_btn;
    logic                     power_switch;
    logic                     car_stopped;
    elevator_pkg::floor_t     current_floor;
    elevator_pkg::floor_t     target_floor;
    elevator_pkg::direction_t direction;
    logic                     activate_elevator;
    logic                     door_open_allowed;
    logic                     door_close_allowed;
    logic [`NUM_FLOORS-1:0]   call_button_lights;
    logic [`NUM_FLOORS-1:0]   panel_button_lights;

    logic [15:0]              steps [0:max_steps-1];
    elevator_pkg::floor_t     car_floor;
    logic                     aborted;

    floor_request_controller floor_request_controller_inst (.*);
    request_checker checker_inst (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic abort_run(input string msg);
        aborted = 1'b1;
        checker_inst.note_failure(msg);
    endtask

    // Button held high for one cycle
    task automatic press(input logic call, input int f);
        @(posedge clock);
        if (call) begin
            floor_call_buttons <= `NUM_FLOORS'(1) << f;
        end else begin
            panel_buttons <= `NUM_FLOORS'(1) << f;
        end
        @(posedge clock);
        floor_call_buttons <= '0;
        panel_buttons      <= '0;
    endtask

    // Car model, one floor every 4 cycles toward the target
    task automatic move_car(input elevator_pkg::floor_t expected);
        int guard;
        guard = 0;
        @(posedge clock);
        while (!activate_elevator && guard < 20) begin
            @(posedge clock);
            guard++;
        end
        if (!activate_elevator) begin
            abort_run("car was never activated");
            return;
        end
        checker_inst.check_value("target_floor", 16'(target_floor), 16'(expected));
        car_stopped <= 1'b0;
        guard = 0;
        while (car_floor != target_floor && guard < 16) begin
            repeat (4) @(posedge clock);
            car_floor     = (target_floor > car_floor) ? car_floor + 1'b1 : car_floor - 1'b1;
            current_floor <= car_floor;
            guard++;
        end
        car_stopped <= 1'b1;
        if (car_floor != target_floor) begin
            abort_run("car never reached its target floor");
            return;
        end
        guard = 0;
        while (activate_elevator && guard < 10) begin
            @(posedge clock);
            guard++;
        end
        if (activate_elevator) begin
            abort_run("activate_elevator stayed high after arrival");
        end
    endtask

    initial begin : main
        int          pc;
        logic [3:0]  op;
        logic [11:0] arg;

        reset_n            = 1'b0;
        floor_call_buttons = '0;
        panel_buttons      = '0;
        door_open_btn      = 1'b0;
        door_close_btn     = 1'b0;
        emergency_btn      = 1'b0;
        power_switch       = 1'b1;
        car_stopped        = 1'b1;
        current_floor      = '0;
        car_floor          = '0;
        aborted            = 1'b0;
        for (int i = 0; i < max_steps; i++) begin
            steps[i] = '0;
        end
        $readmemh("tests/floor_requests_tests.txt", steps);

        repeat (8) @(posedge clock);
        reset_n <= 1'b1;
        @(posedge clock);

        pc = 0;
        while (!aborted && pc < max_steps && steps[pc][15:12] != 4'h0) begin
            op  = steps[pc][15:12];
            arg = steps[pc][11:0];
            case (op)
                4'h1: press(1'b0, int'(arg[3:0]));
                4'h2: press(1'b1, int'(arg[3:0]));
                4'h3: move_car(arg[3:0]);
                4'h4: begin
                    @(posedge clock);
                    power_switch <= arg[0];
                end
                4'h5: begin
                    @(posedge clock);
                    emergency_btn <= arg[0];
                end
                4'h6: checker_inst.check_value("panel_button_lights",
                                               16'(panel_button_lights), 16'(arg));
                4'h7: checker_inst.check_value("call_button_lights",
                                               16'(call_button_lights), 16'(arg));
                4'h8: repeat (int'(arg)) @(posedge clock);
                4'h9: begin
                    @(posedge clock);
                    door_open_btn  <= arg[0];
                    door_close_btn <= arg[1];
                end
                4'hA: checker_inst.check_value("activate_elevator",
                                               16'(activate_elevator), 16'(arg));
                4'hB: checker_inst.check_value("{door_close_allowed,door_open_allowed}",
                                               16'({door_close_allowed, door_open_allowed}),
                                               16'(arg));
                default: abort_run("unknown step code in stimulus file");
            endcase
            pc++;
        end

        // An empty step list or one without its end marker means lost stimulus
        if (pc == 0) begin
            checker_inst.note_failure("no steps were read from the stimulus file");
        end else if (pc == max_steps) begin
            checker_inst.note_failure("stimulus file has no end marker");
        end

        checker_inst.report();
        if (checker_inst.value_errors == 0 && checker_inst.other_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
